// File: list.f
src/lsq_pkg.sv
src/lsq_entry.sv
src/lsq_entry_array.sv
src/lsq_control.sv
src/lsq_mem_port.sv
src/lsq_top.sv
tests/lsq_mem_model.sv
tests/lsq_checker.sv
tests/lsq_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module lsq_tb -o lsq_sim &&
./obj_dir/lsq_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: src/lsq_control.sv
////////////////////
// Queue pointers for the load/store queue
// Compacted allocation, flush rewind, full and empty
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_control #(
  parameter int DEPTH = 16
) (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      flush,
  input  wire                      pop,
  input  wire                      disp_valid_1,
  input  wire                      disp_valid_2,
  input  wire [DEPTH-1:0]          valid_mask,
  input  wire [DEPTH-1:0]          committed_mask,
  output logic [$clog2(DEPTH)-1:0] head_ptr,
  output logic [$clog2(DEPTH)-1:0] alloc_1_ptr,
  output logic [$clog2(DEPTH)-1:0] alloc_2_ptr,
  output logic                     alloc_1_en,
  output logic                     alloc_2_en,
  output logic                     full,
  output logic                     empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [PTR_W-1:0] tail_ptr;
  logic [PTR_W-1:0] next_tail;
  logic [PTR_W-1:0] keep_count;
  logic [CNT_W-1:0] used_count;

  // Slot 2 takes the tail when slot 1 is idle
  assign alloc_1_en  = disp_valid_1;
  assign alloc_2_en  = disp_valid_2;
  assign alloc_1_ptr = tail_ptr;
  assign alloc_2_ptr = disp_valid_1 ? tail_ptr + PTR_W'(1) : tail_ptr;

  assign next_tail = tail_ptr + PTR_W'(disp_valid_1) + PTR_W'(disp_valid_2);

  // Occupancy and surviving stores
  always_comb begin
    used_count = '0;
    keep_count = '0;
    for (int i = 0; i < DEPTH; i++) begin
      used_count = used_count + CNT_W'(valid_mask[i]);
      keep_count = keep_count + PTR_W'(committed_mask[i]);
    end
  end

  ////////////////////
  // Pointer registers
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (pop) begin
        head_ptr <= head_ptr + PTR_W'(1);
      end
      // Committed stores sit contiguously from the head
      if (flush) begin
        tail_ptr <= head_ptr + keep_count;
      end else begin
        tail_ptr <= next_tail;
      end
    end
  end

  // A paired dispatch needs two free slots
  assign full  = used_count > CNT_W'(DEPTH - 2);
  assign empty = ~valid_mask[head_ptr];

endmodule

`default_nettype wire

// File: src/lsq_entry.sv
////////////////////
// One load/store queue slot
// Tag, kind, address, data, complete and committed flags
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_entry (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           clear,
  input  wire                           alloc,
  input  wire                           alloc_load,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  alloc_tag,
  input  wire                           ex_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_1,
  input  wire                           ex_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_2,
  input  wire                           rob_head_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_1,
  input  wire                           rob_head_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_2,
  output logic                          valid,
  output logic                          load,
  output logic [lsq_pkg::ROB_TAG_W-1:0] tag,
  output logic [lsq_pkg::XLEN-1:0]      addr,
  output logic [lsq_pkg::XLEN-1:0]      data,
  output logic                          ready,
  output logic                          committed
);

  import lsq_pkg::*;

  logic                 complete;
  logic                 cur_valid;
  logic [ROB_TAG_W-1:0] cur_tag;
  logic                 hit_1;
  logic                 hit_2;
  logic                 head_hit;

  // Tag seen this cycle, so a result can land in the allocating cycle
  assign cur_valid = alloc | (valid & ~clear);
  assign cur_tag   = alloc ? alloc_tag : tag;

  // Bus 1 wins when both buses carry our tag
  assign hit_1 = cur_valid & ex_valid_1 & (ex_tag_1 == cur_tag);
  assign hit_2 = cur_valid & ex_valid_2 & (ex_tag_2 == cur_tag) & ~hit_1;

  assign head_hit = (rob_head_valid_1 & (rob_head_1 == tag)) |
                    (rob_head_valid_2 & (rob_head_2 == tag));

  always_ff @(posedge clock) begin
    if (reset) begin
      valid     <= 1'b0;
      complete  <= 1'b0;
      committed <= 1'b0;
    end else if (alloc) begin
      valid     <= 1'b1;
      complete  <= hit_1 | hit_2;
      committed <= 1'b0;
    end else if (clear) begin
      valid     <= 1'b0;
      complete  <= 1'b0;
      committed <= 1'b0;
    end else begin
      if (hit_1 | hit_2) begin
        complete <= 1'b1;
      end
      // Store retires from the ROB only once its operands are in
      if (valid & complete & ~load & head_hit) begin
        committed <= 1'b1;
      end
    end
  end

  ////////////////////
  // Payload
  ////////////////////
  always_ff @(posedge clock) begin
    if (alloc) begin
      load <= alloc_load;
      tag  <= alloc_tag;
    end
    if (hit_1) begin
      addr <= ex_addr_1;
      data <= ex_data_1;
    end else if (hit_2) begin
      addr <= ex_addr_2;
      data <= ex_data_2;
    end
  end

  assign ready = valid & complete & (load | committed);

endmodule

`default_nettype wire

// File: src/lsq_entry_array.sv
////////////////////
// Slot array of the load/store queue
// Per-slot allocate and clear decode
// Head slot output mux
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_entry_array #(
  parameter int DEPTH = 16
) (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           flush,
  input  wire                           pop,
  input  wire [$clog2(DEPTH)-1:0]       head_ptr,
  input  wire [$clog2(DEPTH)-1:0]       alloc_1_ptr,
  input  wire [$clog2(DEPTH)-1:0]       alloc_2_ptr,
  input  wire                           alloc_1_en,
  input  wire                           alloc_2_en,
  input  wire                           disp_load_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  disp_tag_1,
  input  wire                           disp_load_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  disp_tag_2,
  input  wire                           ex_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_1,
  input  wire                           ex_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_2,
  input  wire                           rob_head_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_1,
  input  wire                           rob_head_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_2,
  output logic [DEPTH-1:0]              valid_mask,
  output logic [DEPTH-1:0]              committed_mask,
  output logic                          head_ready,
  output logic                          head_load,
  output logic [lsq_pkg::ROB_TAG_W-1:0] head_tag,
  output logic [lsq_pkg::XLEN-1:0]      head_addr,
  output logic [lsq_pkg::XLEN-1:0]      head_data
);

  import lsq_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [DEPTH-1:0]     ready_mask;
  logic [DEPTH-1:0]     load_mask;
  logic [ROB_TAG_W-1:0] tag_arr  [DEPTH];
  logic [XLEN-1:0]      addr_arr [DEPTH];
  logic [XLEN-1:0]      data_arr [DEPTH];

  for (genvar i = 0; i < DEPTH; i++) begin : g_slot
    logic                 sel_1;
    logic                 sel_2;
    logic                 slot_alloc;
    logic                 slot_load;
    logic [ROB_TAG_W-1:0] slot_tag;
    logic                 slot_clear;

    assign sel_1      = alloc_1_en & (alloc_1_ptr == PTR_W'(i));
    assign sel_2      = alloc_2_en & (alloc_2_ptr == PTR_W'(i));
    assign slot_alloc = sel_1 | sel_2;
    assign slot_load  = sel_1 ? disp_load_1 : disp_load_2;
    assign slot_tag   = sel_1 ? disp_tag_1 : disp_tag_2;

    // Committed stores survive a flush and still drain
    assign slot_clear = (pop & (head_ptr == PTR_W'(i))) |
                        (flush & ~committed_mask[i]);

    lsq_entry u_entry (
      .clock            (clock),
      .reset            (reset),
      .clear            (slot_clear),
      .alloc            (slot_alloc),
      .alloc_load       (slot_load),
      .alloc_tag        (slot_tag),
      .ex_valid_1       (ex_valid_1),
      .ex_tag_1         (ex_tag_1),
      .ex_addr_1        (ex_addr_1),
      .ex_data_1        (ex_data_1),
      .ex_valid_2       (ex_valid_2),
      .ex_tag_2         (ex_tag_2),
      .ex_addr_2        (ex_addr_2),
      .ex_data_2        (ex_data_2),
      .rob_head_valid_1 (rob_head_valid_1),
      .rob_head_1       (rob_head_1),
      .rob_head_valid_2 (rob_head_valid_2),
      .rob_head_2       (rob_head_2),
      .valid            (valid_mask[i]),
      .load             (load_mask[i]),
      .tag              (tag_arr[i]),
      .addr             (addr_arr[i]),
      .data             (data_arr[i]),
      .ready            (ready_mask[i]),
      .committed        (committed_mask[i])
    );
  end

  ////////////////////
  // Head slot mux
  ////////////////////
  assign head_ready = ready_mask[head_ptr];
  assign head_load  = load_mask[head_ptr];
  assign head_tag   = tag_arr[head_ptr];
  assign head_addr  = addr_arr[head_ptr];
  assign head_data  = data_arr[head_ptr];

endmodule

`default_nettype wire

// File: src/lsq_mem_port.sv
////////////////////
// Data-memory port of the load/store queue
// Command, outstanding tag, load result, stall
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_mem_port (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           flush,
  input  wire                           head_ready,
  input  wire                           head_load,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  head_tag,
  input  wire [lsq_pkg::XLEN-1:0]       head_addr,
  input  wire [lsq_pkg::XLEN-1:0]       head_data,
  input  wire [lsq_pkg::MEM_TAG_W-1:0]  mem_response,
  input  wire [lsq_pkg::MEM_TAG_W-1:0]  mem_tag,
  input  wire [lsq_pkg::XLEN-1:0]       mem_rdata,
  output lsq_pkg::bus_cmd_e             mem_cmd,
  output logic [lsq_pkg::XLEN-1:0]      mem_addr,
  output logic [lsq_pkg::XLEN-1:0]      mem_data,
  output logic                          pop,
  output logic                          stall,
  output logic                          result_valid,
  output logic [lsq_pkg::ROB_TAG_W-1:0] result_tag,
  output logic [lsq_pkg::XLEN-1:0]      result_data
);

  import lsq_pkg::*;

  logic [MEM_TAG_W-1:0] out_tag;
  logic                 waiting;
  logic                 issue;
  logic                 accept;
  logic                 load_done;

  assign waiting = out_tag != '0;

  // One request in flight at a time
  assign issue   = head_ready & ~waiting;
  assign mem_cmd = !issue ? BUS_NONE : head_load ? BUS_LOAD : BUS_STORE;

  // Head does not move until finish, so these hold under busy
  assign mem_addr = head_addr;
  assign mem_data = head_data;

  assign accept    = issue & (mem_response != '0);
  assign load_done = waiting & (mem_tag == out_tag);

  ////////////////////
  // Outstanding load tag
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_tag <= '0;
    end else if (accept && head_load) begin
      out_tag <= mem_response;
    end else if (load_done) begin
      out_tag <= '0;
    end
  end

  assign pop   = (accept & ~head_load) | load_done;
  assign stall = head_ready & ~pop;

  assign result_valid = load_done;
  assign result_tag   = head_tag;
  assign result_data  = mem_rdata;

endmodule

`default_nettype wire

// File: src/lsq_pkg.sv
////////////////////
// Shared widths for the load/store queue
// Memory bus command encoding
////////////////////
`default_nettype none

package lsq_pkg;

  // Address and data width
  localparam int XLEN = 64;

  // Reorder-buffer tag width
  localparam int ROB_TAG_W = 5;

  // Memory transaction tag width, tag 0 means no transaction
  localparam int MEM_TAG_W = 4;

  ////////////////////
  // Memory bus commands
  ////////////////////
  typedef enum logic [1:0] {
    BUS_NONE  = 2'b00,
    BUS_LOAD  = 2'b01,
    BUS_STORE = 2'b10
  } bus_cmd_e;

endpackage

`default_nettype wire

// File: src/lsq_top.sv
////////////////////
// Load/store queue top level
// Control, slot array and memory port
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_top #(
  parameter int DEPTH = 16
) (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           flush,
  input  wire                           disp_valid_1,
  input  wire                           disp_load_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  disp_tag_1,
  input  wire                           disp_valid_2,
  input  wire                           disp_load_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  disp_tag_2,
  input  wire                           ex_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_1,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_1,
  input  wire                           ex_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  ex_tag_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_addr_2,
  input  wire [lsq_pkg::XLEN-1:0]       ex_data_2,
  input  wire                           rob_head_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_1,
  input  wire                           rob_head_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0]  rob_head_2,
  output lsq_pkg::bus_cmd_e             mem_cmd,
  output logic [lsq_pkg::XLEN-1:0]      mem_addr,
  output logic [lsq_pkg::XLEN-1:0]      mem_data,
  input  wire [lsq_pkg::MEM_TAG_W-1:0]  mem_response,
  input  wire [lsq_pkg::MEM_TAG_W-1:0]  mem_tag,
  input  wire [lsq_pkg::XLEN-1:0]       mem_rdata,
  output logic                          result_valid,
  output logic [lsq_pkg::ROB_TAG_W-1:0] result_tag,
  output logic [lsq_pkg::XLEN-1:0]      result_data,
  output logic                          stall,
  output logic                          full,
  output logic                          empty
);

  import lsq_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0]     head_ptr;
  logic [PTR_W-1:0]     alloc_1_ptr;
  logic [PTR_W-1:0]     alloc_2_ptr;
  logic                 alloc_1_en;
  logic                 alloc_2_en;
  logic                 pop;
  logic [DEPTH-1:0]     valid_mask;
  logic [DEPTH-1:0]     committed_mask;
  logic                 head_ready;
  logic                 head_load;
  logic [ROB_TAG_W-1:0] head_tag;
  logic [XLEN-1:0]      head_addr;
  logic [XLEN-1:0]      head_data;

  ////////////////////
  // Pointers
  ////////////////////
  lsq_control #(
    .DEPTH (DEPTH)
  ) u_control (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .pop            (pop),
    .disp_valid_1   (disp_valid_1),
    .disp_valid_2   (disp_valid_2),
    .valid_mask     (valid_mask),
    .committed_mask (committed_mask),
    .head_ptr       (head_ptr),
    .alloc_1_ptr    (alloc_1_ptr),
    .alloc_2_ptr    (alloc_2_ptr),
    .alloc_1_en     (alloc_1_en),
    .alloc_2_en     (alloc_2_en),
    .full           (full),
    .empty          (empty)
  );

  ////////////////////
  // Slots
  ////////////////////
  lsq_entry_array #(
    .DEPTH (DEPTH)
  ) u_array (
    .clock            (clock),
    .reset            (reset),
    .flush            (flush),
    .pop              (pop),
    .head_ptr         (head_ptr),
    .alloc_1_ptr      (alloc_1_ptr),
    .alloc_2_ptr      (alloc_2_ptr),
    .alloc_1_en       (alloc_1_en),
    .alloc_2_en       (alloc_2_en),
    .disp_load_1      (disp_load_1),
    .disp_tag_1       (disp_tag_1),
    .disp_load_2      (disp_load_2),
    .disp_tag_2       (disp_tag_2),
    .ex_valid_1       (ex_valid_1),
    .ex_tag_1         (ex_tag_1),
    .ex_addr_1        (ex_addr_1),
    .ex_data_1        (ex_data_1),
    .ex_valid_2       (ex_valid_2),
    .ex_tag_2         (ex_tag_2),
    .ex_addr_2        (ex_addr_2),
    .ex_data_2        (ex_data_2),
    .rob_head_valid_1 (rob_head_valid_1),
    .rob_head_1       (rob_head_1),
    .rob_head_valid_2 (rob_head_valid_2),
    .rob_head_2       (rob_head_2),
    .valid_mask       (valid_mask),
    .committed_mask   (committed_mask),
    .head_ready       (head_ready),
    .head_load        (head_load),
    .head_tag         (head_tag),
    .head_addr        (head_addr),
    .head_data        (head_data)
  );

  ////////////////////
  // Memory side
  ////////////////////
  lsq_mem_port u_mem_port (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .head_ready   (head_ready),
    .head_load    (head_load),
    .head_tag     (head_tag),
    .head_addr    (head_addr),
    .head_data    (head_data),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_rdata    (mem_rdata),
    .mem_cmd      (mem_cmd),
    .mem_addr     (mem_addr),
    .mem_data     (mem_data),
    .pop          (pop),
    .stall        (stall),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

endmodule

`default_nettype wire

// File: tests/lsq_checker.sv
////////////////////
// Scoreboard for the load/store queue
// Program-order mirror, store writes, load results
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_checker #(
  parameter int DEPTH = 16
) (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          flush,
  input  wire                          disp_valid_1,
  input  wire                          disp_load_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] disp_tag_1,
  input  wire                          disp_valid_2,
  input  wire                          disp_load_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] disp_tag_2,
  input  wire                          ex_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] ex_tag_1,
  input  wire [lsq_pkg::XLEN-1:0]      ex_addr_1,
  input  wire [lsq_pkg::XLEN-1:0]      ex_data_1,
  input  wire                          ex_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] ex_tag_2,
  input  wire [lsq_pkg::XLEN-1:0]      ex_addr_2,
  input  wire [lsq_pkg::XLEN-1:0]      ex_data_2,
  input  wire                          rob_head_valid_1,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] rob_head_1,
  input  wire                          rob_head_valid_2,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] rob_head_2,
  input  lsq_pkg::bus_cmd_e            mem_cmd,
  input  wire [lsq_pkg::XLEN-1:0]      mem_addr,
  input  wire [lsq_pkg::XLEN-1:0]      mem_data,
  input  wire [lsq_pkg::MEM_TAG_W-1:0] mem_response,
  input  wire                          result_valid,
  input  wire [lsq_pkg::ROB_TAG_W-1:0] result_tag,
  input  wire [lsq_pkg::XLEN-1:0]      result_data,
  input  wire                          stall,
  input  wire                          full,
  input  wire                          empty,
  output int                           op_count,
  output int                           error_count
);

  import lsq_pkg::*;

  typedef struct packed {
    logic [ROB_TAG_W-1:0] tag;
    logic                 load;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      data;
    logic                 complete;
    logic                 committed;
  } op_t;

  op_t             q[$];
  op_t             kept[$];
  op_t             front;
  logic [XLEN-1:0] shadow [logic [XLEN-1:0]];
  logic            held;
  logic            load_out;
  bus_cmd_e        held_cmd;
  logic [XLEN-1:0] held_addr;
  logic [XLEN-1:0] held_data;
  int              errs_before;

  initial begin
    op_count    = 0;
    error_count = 0;
    held        = 1'b0;
    load_out    = 1'b0;
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("At %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // Memory contents as the committed stores leave them
  function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] a);
    return shadow.exists(a) ? shadow[a] : ~a;
  endfunction

  task automatic close_test(input string what, input logic [ROB_TAG_W-1:0] tag);
    op_count++;
    $display("%s tag %0d: %s", what, tag, (error_count == errs_before) ? "ok" : "mismatch");
  endtask

  always @(negedge clock) begin
    if (reset) begin
      q.delete();
      shadow.delete();
      held     = 1'b0;
      load_out = 1'b0;
    end else begin
      errs_before = error_count;
      check_value("full", 64'(full), 64'(q.size() > DEPTH - 2));
      check_value("empty", 64'(empty), 64'(q.size() == 0));
      // Busy command must be held as is
      if (held) begin
        check_value("mem_cmd", 64'(mem_cmd), 64'(held_cmd));
        check_value("mem_addr", mem_addr, held_addr);
        check_value("mem_data", mem_data, held_data);
      end
      held = 1'b0;

      ////////////////////
      // Memory bus
      ////////////////////
      if (mem_cmd != BUS_NONE) begin
        if (load_out) begin
          report_fail("memory command issued while a load is outstanding");
        end
        if (q.size() == 0) begin
          report_fail("memory command issued with nothing queued");
        end else begin
          front = q[0];
          check_value("mem_cmd", 64'(mem_cmd), 64'(front.load ? BUS_LOAD : BUS_STORE));
          check_value("mem_addr", mem_addr, front.addr);
          if (!front.load) begin
            if (!front.committed) report_fail("store reached the bus before commit");
            check_value("mem_data", mem_data, front.data);
          end
          if (mem_response == '0) begin
            check_value("stall", 64'(stall), 64'd1);
            held      = !flush;
            held_cmd  = mem_cmd;
            held_addr = mem_addr;
            held_data = mem_data;
          end else if (!front.load) begin
            shadow[front.addr] = front.data;
            void'(q.pop_front());
            close_test("Store", front.tag);
          end else begin
            load_out = 1'b1;
          end
        end
      end
      if (result_valid) begin
        if (q.size() == 0 || !q[0].load || !load_out) begin
          report_fail("load result without an accepted load at the head");
        end else begin
          front = q.pop_front();
          check_value("result_tag", 64'(result_tag), 64'(front.tag));
          check_value("result_data", result_data, expected_word(front.addr));
          close_test("Load", front.tag);
        end
        load_out = 1'b0;
      end

      // Only committed stores outlive a flush
      if (flush) begin
        kept.delete();
        foreach (q[i]) if (!q[i].load && q[i].committed) kept.push_back(q[i]);
        q = kept;
        load_out = 1'b0;
      end
      if (disp_valid_1) q.push_back({disp_tag_1, disp_load_1, 64'd0, 64'd0, 2'b00});
      if (disp_valid_2) q.push_back({disp_tag_2, disp_load_2, 64'd0, 64'd0, 2'b00});
      foreach (q[i]) begin
        if (!q[i].load && q[i].complete &&
            ((rob_head_valid_1 && rob_head_1 == q[i].tag) ||
             (rob_head_valid_2 && rob_head_2 == q[i].tag))) begin
          q[i].committed = 1'b1;
        end
        if (ex_valid_1 && ex_tag_1 == q[i].tag) begin
          q[i].addr     = ex_addr_1;
          q[i].data     = ex_data_1;
          q[i].complete = 1'b1;
        end else if (ex_valid_2 && ex_tag_2 == q[i].tag) begin
          q[i].addr     = ex_addr_2;
          q[i].data     = ex_data_2;
          q[i].complete = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/lsq_mem_model.sv
////////////////////
// Tagged data-memory model
// Random busy cycles and load latency
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_mem_model (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          hold_busy,
  input  lsq_pkg::bus_cmd_e            mem_cmd,
  input  wire [lsq_pkg::XLEN-1:0]      mem_addr,
  input  wire [lsq_pkg::XLEN-1:0]      mem_data,
  output logic [lsq_pkg::MEM_TAG_W-1:0] mem_response,
  output logic [lsq_pkg::MEM_TAG_W-1:0] mem_tag,
  output logic [lsq_pkg::XLEN-1:0]      mem_rdata
);

  import lsq_pkg::*;

  logic [XLEN-1:0]      words [logic [XLEN-1:0]];
  logic [31:0]          rng;
  logic                 pend;
  logic [MEM_TAG_W-1:0] pend_tag;
  logic [MEM_TAG_W-1:0] next_tag;
  logic [XLEN-1:0]      pend_addr;
  int                   lat;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    mem_response = '0;
    mem_tag      = '0;
    mem_rdata    = '0;
    rng          = 32'h0cd2_52a8;
    pend         = 1'b0;
    pend_tag     = '0;
    pend_addr    = '0;
    next_tag     = 4'd1;
    lat          = 0;
    forever begin
      // Requests are sampled mid-cycle
      @(negedge clock);
      if (!reset && mem_cmd != BUS_NONE && mem_response != '0) begin
        if (mem_cmd == BUS_STORE) begin
          words[mem_addr] = mem_data;
        end else begin
          rng       = xorshift(rng);
          pend      = 1'b1;
          pend_tag  = mem_response;
          pend_addr = mem_addr;
          lat       = int'(rng[1:0]);
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      @(posedge clock);
      #2;
      mem_tag = '0;
      if (pend && lat == 0) begin
        mem_tag   = pend_tag;
        mem_rdata = words.exists(pend_addr) ? words[pend_addr] : ~pend_addr;
        pend      = 1'b0;
      end else if (pend) begin
        lat = lat - 1;
      end
      rng = xorshift(rng);
      mem_response = (hold_busy || rng[7:6] == 2'b00) ? '0 : next_tag;
    end
  end

endmodule

`default_nettype wire

// File: tests/lsq_tb.sv
////////////////////
// Testbench top for the load/store queue
// Clock, reset, operation table, drive loop
////////////////////
`default_nettype none
`timescale 1ns/1ps

module lsq_tb;

  import lsq_pkg::*;

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 300;

  logic clock, reset, flush, hold_busy;
  logic disp_valid_1, disp_load_1, disp_valid_2, disp_load_2;
  logic [ROB_TAG_W-1:0] disp_tag_1, disp_tag_2, ex_tag_1, ex_tag_2, rob_head_1, rob_head_2;
  logic ex_valid_1, ex_valid_2, rob_head_valid_1, rob_head_valid_2;
  logic [XLEN-1:0] ex_addr_1, ex_data_1, ex_addr_2, ex_data_2;
  bus_cmd_e mem_cmd;
  logic [XLEN-1:0] mem_addr, mem_data, mem_rdata, result_data;
  logic [MEM_TAG_W-1:0] mem_response, mem_tag;
  logic [ROB_TAG_W-1:0] result_tag;
  logic result_valid, stall, full, empty, timed_out;
  int op_count, error_count, row_count, i;

  ////////////////////
  // Operation table
  ////////////////////
  logic            row_load   [16];
  logic [4:0]      row_tag    [16];
  logic [XLEN-1:0] row_addr   [16];
  logic [XLEN-1:0] row_data   [16];
  int              row_slot   [16];
  int              row_bus    [16];
  logic            row_commit [16];
  logic            row_flush  [16];

  lsq_top #(.DEPTH(DEPTH)) dut0 (.*);

  lsq_mem_model mem0 (.*);

  lsq_checker #(.DEPTH(DEPTH)) check0 (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic add_row(input logic ld, input logic [4:0] tag, input logic [63:0] addr,
                         input logic [63:0] data, input int slot, input int bus,
                         input logic commit, input logic fl);
    row_load[row_count]   = ld;
    row_tag[row_count]    = tag;
    row_addr[row_count]   = addr;
    row_data[row_count]   = data;
    row_slot[row_count]   = slot;
    row_bus[row_count]    = bus;
    row_commit[row_count] = commit;
    row_flush[row_count]  = fl;
    row_count++;
  endtask

  task automatic execute(input int bus, input logic [4:0] tag, input logic [63:0] addr,
                         input logic [63:0] data);
    if (bus == 1) begin
      {ex_valid_1, ex_tag_1, ex_addr_1, ex_data_1} = {1'b1, tag, addr, data};
    end else begin
      {ex_valid_2, ex_tag_2, ex_addr_2, ex_data_2} = {1'b1, tag, addr, data};
    end
    step();
    ex_valid_1 = 1'b0;
    ex_valid_2 = 1'b0;
  endtask

  task automatic wait_level(input string name, input logic level);
    int n;
    n = 0;
    while ((name == "empty" ? empty : full) !== level && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("Timed out waiting for %s to reach %0d", name, level);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_group(input int first, input int n);
    logic fl;
    logic any_commit;
    fl = row_flush[first] | (n == 2 && row_flush[first + 1]);
    any_commit = row_commit[first] | (n == 2 && row_commit[first + 1]);
    hold_busy = fl;
    for (int k = first; k < first + n; k++) begin
      if (row_slot[k] == 1) begin
        {disp_valid_1, disp_load_1, disp_tag_1} = {1'b1, row_load[k], row_tag[k]};
      end else begin
        {disp_valid_2, disp_load_2, disp_tag_2} = {1'b1, row_load[k], row_tag[k]};
      end
    end
    step();
    disp_valid_1 = 1'b0;
    disp_valid_2 = 1'b0;
    // Younger operation executes first
    for (int k = first + n - 1; k >= first; k--) begin
      execute(row_bus[k], row_tag[k], row_addr[k], row_data[k]);
    end
    if (any_commit) begin
      repeat (3) step();
      // Commit arrives on the ROB head port numbered like the execute bus
      for (int k = first; k < first + n; k++) begin
        if (row_commit[k] && row_bus[k] == 1) begin
          {rob_head_valid_1, rob_head_1} = {1'b1, row_tag[k]};
        end else if (row_commit[k]) begin
          {rob_head_valid_2, rob_head_2} = {1'b1, row_tag[k]};
        end
      end
      step();
      rob_head_valid_1 = 1'b0;
      rob_head_valid_2 = 1'b0;
    end
    if (fl) begin
      flush = 1'b1;
      step();
      flush = 1'b0;
    end
    hold_busy = 1'b0;
    wait_level("empty", 1'b1);
  endtask

  // Seven loads with no address yet leave one slot free
  task automatic fill_queue();
    for (int k = 0; k < 7; k++) begin
      {disp_valid_1, disp_load_1, disp_tag_1} = {1'b1, 1'b1, 5'(16 + k)};
      if (k < 6) begin
        {disp_valid_2, disp_load_2, disp_tag_2} = {1'b1, 1'b1, 5'(17 + k)};
        k++;
      end
      step();
      disp_valid_1 = 1'b0;
      disp_valid_2 = 1'b0;
    end
    wait_level("full", 1'b1);
    execute(1, 5'd16, 64'h700, 64'd0);
    wait_level("full", 1'b0);
    for (int k = 1; k < 7; k++) execute(2, 5'(16 + k), 64'h700 + 64'(8 * k), 64'd0);
    wait_level("empty", 1'b1);
  endtask

  initial begin
    {reset, flush, hold_busy, timed_out} = 4'b1000;
    {disp_valid_1, disp_load_1, disp_tag_1, disp_valid_2, disp_load_2, disp_tag_2} = '0;
    {ex_valid_1, ex_tag_1, ex_addr_1, ex_data_1} = '0;
    {ex_valid_2, ex_tag_2, ex_addr_2, ex_data_2} = '0;
    {rob_head_valid_1, rob_head_1, rob_head_valid_2, rob_head_2} = '0;
    row_count = 0;
    add_row(1'b1, 5'd1, 64'h100, 64'd0, 1, 1, 1'b0, 1'b0);
    add_row(1'b0, 5'd2, 64'h200, 64'h1122_3344_5566_7788, 1, 2, 1'b1, 1'b0);
    add_row(1'b1, 5'd3, 64'h200, 64'd0, 1, 1, 1'b0, 1'b0);
    add_row(1'b0, 5'd4, 64'h300, 64'hcafe_f00d_0bad_beef, 1, 2, 1'b1, 1'b0);
    add_row(1'b1, 5'd5, 64'h300, 64'd0, 2, 1, 1'b0, 1'b0);
    add_row(1'b1, 5'd6, 64'h400, 64'd0, 1, 1, 1'b0, 1'b0);
    add_row(1'b1, 5'd7, 64'h408, 64'd0, 2, 2, 1'b0, 1'b0);
    add_row(1'b0, 5'd8, 64'h500, 64'ha5a5_0000_1111_2222, 1, 1, 1'b1, 1'b0);
    add_row(1'b0, 5'd9, 64'h508, 64'h5a5a_3333_4444_5555, 2, 2, 1'b0, 1'b1);
    add_row(1'b1, 5'd10, 64'h508, 64'd0, 1, 1, 1'b0, 1'b0);
    add_row(1'b1, 5'd11, 64'h500, 64'd0, 2, 2, 1'b0, 1'b0);
    add_row(1'b0, 5'd12, 64'h600, 64'h0123_4567_89ab_cdef, 1, 1, 1'b1, 1'b0);
    add_row(1'b1, 5'd13, 64'h600, 64'd0, 2, 2, 1'b0, 1'b1);
    add_row(1'b1, 5'd14, 64'h600, 64'd0, 1, 2, 1'b0, 1'b0);
    repeat (3) step();
    reset = 1'b0;
    i = 0;
    while (i < row_count && !timed_out) begin
      if (i + 1 < row_count && row_slot[i + 1] == 2) begin
        run_group(i, 2);
        i += 2;
      end else begin
        run_group(i, 1);
        i += 1;
      end
    end
    if (!timed_out) fill_queue();
    repeat (3) step();
    $display("Operations checked: %0d, errors: %0d", op_count, error_count);
    if (timed_out || error_count != 0 || op_count != 19) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire
